//--- Makefile
SIM      = verilator
TOP      = lenet_mac_array_tb
FILELIST = lenet_mac_array.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- design/lenet_approx_mult.sv
`timescale 1ns/1ns
`default_nettype none

module lenet_approx_mult (
    input  wire lenet_mac_pkg::act_t     x,
    input  wire lenet_mac_pkg::weight_t  y,
    output lenet_mac_pkg::product_t      z
);

    import lenet_mac_pkg::*;

    weight_t     pp [8];     // partial product rows, row i weighs 2**i.
    logic [12:0] corr [5];   // compressed rows 0 to 5.

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // rows 0 to 5 are never summed exactly; adjacent pairs are merged
    // bit by bit into five sparse correction terms.
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            corr[k] = '0;
        end

        corr[0][3]  = pp[0][3] | pp[1][2];
        corr[0][4]  = pp[0][4] & pp[1][3];
        corr[0][6]  = pp[0][6] | pp[1][5];
        corr[0][7]  = pp[0][7] ^ pp[1][6];
        corr[0][8]  = pp[1][7];
        corr[0][9]  = pp[2][6] & pp[3][5];
        corr[0][10] = pp[3][7];
        corr[0][11] = pp[4][6] & pp[5][5];
        corr[0][12] = pp[4][7] & pp[5][6];

        corr[1][4]  = pp[2][2] & pp[3][1];
        corr[1][6]  = pp[4][1] & pp[5][0];
        corr[1][7]  = pp[2][4] ^ pp[3][3];
        corr[1][8]  = pp[2][5] | pp[3][4];
        corr[1][9]  = pp[2][7] | pp[3][6];
        corr[1][10] = pp[4][5] & pp[5][4];
        corr[1][11] = pp[4][7] ^ pp[5][6];
        corr[1][12] = pp[5][7];

        corr[2][6]  = pp[4][1] | pp[5][0];
        corr[2][7]  = pp[4][3] ^ pp[5][2];
        corr[2][8]  = pp[2][6] ^ pp[3][5];
        corr[2][9]  = pp[4][5] ^ pp[5][4];
        corr[2][10] = pp[4][6] ^ pp[5][5];

        corr[3][8]  = pp[4][4] & pp[5][3];  // carry-like term.
        corr[4][8]  = pp[4][4] | pp[5][3];
    end

    // the two top rows stay exact.
    assign z = product_t'({pp[6], 6'b0})
             + product_t'({pp[7], 7'b0})
             + product_t'(corr[0])
             + product_t'(corr[1])
             + product_t'(corr[2])
             + product_t'(corr[3])
             + product_t'(corr[4]);

endmodule

`default_nettype wire

//--- design/lenet_mac_array.sv
`timescale 1ns/1ns
`default_nettype none

module lenet_mac_array #(
    parameter  int LANES       = lenet_mac_pkg::DEFAULT_LANES,
    parameter  int KERNEL_TAPS = lenet_mac_pkg::DEFAULT_TAPS,
    parameter  int OUT_SHIFT   = lenet_mac_pkg::DEFAULT_OUT_SHIFT,
    localparam int TAP_W       = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1,
    localparam int LANE_W      = (LANES > 1) ? $clog2(LANES) : 1
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          pixel_valid,
    input  wire lenet_mac_pkg::act_t     pixel,
    input  wire                          weight_wr,
    input  wire [LANE_W-1:0]             weight_lane,
    input  wire [TAP_W-1:0]              weight_tap,
    input  wire lenet_mac_pkg::weight_t  weight_data,
    output logic                         result_valid,
    output logic [LANE_W-1:0]            result_lane,
    output lenet_mac_pkg::act_t          result_data
);

    import lenet_mac_pkg::*;

    logic             tap_valid;
    act_t             tap_pixel;
    logic [TAP_W-1:0] tap_index;
    logic             tap_first;
    logic             tap_last;
    logic [LANES-1:0] lane_wr;
    logic [TAP_W-1:0] wr_tap;
    weight_t          wr_data;
    logic [LANES-1:0] lane_done;
    acc_t             lane_sum [LANES];

    tap_feeder #(
        .LANES       (LANES),
        .KERNEL_TAPS (KERNEL_TAPS)
    ) u_feeder (
        .clk         (clk),
        .arst_n      (arst_n),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .weight_wr   (weight_wr),
        .weight_lane (weight_lane),
        .weight_tap  (weight_tap),
        .weight_data (weight_data),
        .tap_valid   (tap_valid),
        .tap_pixel   (tap_pixel),
        .tap_index   (tap_index),
        .tap_first   (tap_first),
        .tap_last    (tap_last),
        .lane_wr     (lane_wr),
        .wr_tap      (wr_tap),
        .wr_data     (wr_data)
    );

    // one lane per output channel.
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        mac_lane #(
            .KERNEL_TAPS (KERNEL_TAPS)
        ) u_lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .tap_valid (tap_valid),
            .tap_pixel (tap_pixel),
            .tap_index (tap_index),
            .tap_first (tap_first),
            .tap_last  (tap_last),
            .wr_en     (lane_wr[i]),
            .wr_tap    (wr_tap),
            .wr_data   (wr_data),
            .done      (lane_done[i]),
            .sum       (lane_sum[i])
        );
    end

    result_drain #(
        .LANES     (LANES),
        .OUT_SHIFT (OUT_SHIFT)
    ) u_drain (
        .clk          (clk),
        .arst_n       (arst_n),
        .lane_done    (lane_done),
        .lane_sum     (lane_sum),
        .result_valid (result_valid),
        .result_lane  (result_lane),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- design/lenet_mac_pkg.sv
`default_nettype none

package lenet_mac_pkg;

    typedef logic [7:0]  act_t;     // unsigned activation, in and out.
    typedef logic [7:0]  weight_t;  // unsigned kernel weight.
    typedef logic [15:0] product_t;
    typedef logic [23:0] acc_t;     // holds 256 full-scale products.

    parameter int DEFAULT_LANES     = 4;   // output channels.
    parameter int DEFAULT_TAPS      = 25;  // one 5x5 kernel.
    parameter int DEFAULT_OUT_SHIFT = 8;

endpackage

`default_nettype wire

//--- design/mac_lane.sv
`timescale 1ns/1ns
`default_nettype none

module mac_lane #(
    parameter  int KERNEL_TAPS = lenet_mac_pkg::DEFAULT_TAPS,
    localparam int TAP_W       = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          tap_valid,
    input  wire lenet_mac_pkg::act_t     tap_pixel,
    input  wire [TAP_W-1:0]              tap_index,
    input  wire                          tap_first,
    input  wire                          tap_last,
    input  wire                          wr_en,
    input  wire [TAP_W-1:0]              wr_tap,
    input  wire lenet_mac_pkg::weight_t  wr_data,
    output logic                         done,
    output lenet_mac_pkg::acc_t          sum
);

    import lenet_mac_pkg::*;

    weight_t  weights [KERNEL_TAPS];
    weight_t  tap_weight;
    product_t mult_out;
    product_t prod;       // stage 1.
    logic     prod_valid;
    logic     prod_first;
    logic     prod_last;
    acc_t     acc;        // stage 2.

    assign tap_weight = weights[tap_index];

    lenet_approx_mult u_mult (
        .x (tap_pixel),
        .y (tap_weight),
        .z (mult_out)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                weights[t] <= '0;
            end
        end else if (wr_en) begin
            weights[wr_tap] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
            done       <= 1'b0;
            acc        <= '0;
        end else begin
            prod_valid <= tap_valid;
            prod_first <= tap_valid && tap_first;
            prod_last  <= tap_valid && tap_last;
            done       <= prod_valid && prod_last;  // one cycle with the final sum.
            if (prod_valid) begin
                acc <= prod_first ? acc_t'(prod) : acc + acc_t'(prod);
            end
        end
    end

    always_ff @(posedge clk) begin
        prod <= mult_out;
    end

    assign sum = acc;

endmodule

`default_nettype wire

//--- design/result_drain.sv
`timescale 1ns/1ns
`default_nettype none

module result_drain #(
    parameter  int LANES     = lenet_mac_pkg::DEFAULT_LANES,
    parameter  int OUT_SHIFT = lenet_mac_pkg::DEFAULT_OUT_SHIFT,
    localparam int LANE_W    = (LANES > 1) ? $clog2(LANES) : 1
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire [LANES-1:0]           lane_done,
    input  wire lenet_mac_pkg::acc_t  lane_sum [LANES],
    output logic                      result_valid,
    output logic [LANE_W-1:0]         result_lane,
    output lenet_mac_pkg::act_t       result_data
);

    import lenet_mac_pkg::*;

    acc_t              sums [LANES];
    acc_t              scaled;
    act_t              clipped;
    logic              busy;
    logic [LANE_W-1:0] lane_cnt;

    // each lane latches its own sum; lane 0 starts the walk.
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (lane_done[i]) begin
                sums[i] <= lane_sum[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            lane_cnt <= '0;
        end else if (lane_done[0]) begin
            busy     <= 1'b1;
            lane_cnt <= '0;
        end else if (busy) begin
            lane_cnt <= lane_cnt + 1'b1;
            if (lane_cnt == LANE_W'(LANES - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    assign scaled  = sums[lane_cnt] >> OUT_SHIFT;
    assign clipped = (scaled > acc_t'(255)) ? 8'hff : scaled[7:0];  // saturate.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result_lane  <= '0;
        end else begin
            result_valid <= busy;
            result_lane  <= lane_cnt;
        end
    end

    always_ff @(posedge clk) begin
        result_data <= clipped;
    end

endmodule

`default_nettype wire

//--- design/tap_feeder.sv
`timescale 1ns/1ns
`default_nettype none

module tap_feeder #(
    parameter  int LANES       = lenet_mac_pkg::DEFAULT_LANES,
    parameter  int KERNEL_TAPS = lenet_mac_pkg::DEFAULT_TAPS,
    localparam int TAP_W       = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1,
    localparam int LANE_W      = (LANES > 1) ? $clog2(LANES) : 1
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          pixel_valid,
    input  wire lenet_mac_pkg::act_t     pixel,
    input  wire                          weight_wr,
    input  wire [LANE_W-1:0]             weight_lane,
    input  wire [TAP_W-1:0]              weight_tap,
    input  wire lenet_mac_pkg::weight_t  weight_data,
    output logic                         tap_valid,
    output lenet_mac_pkg::act_t          tap_pixel,
    output logic [TAP_W-1:0]             tap_index,
    output logic                         tap_first,
    output logic                         tap_last,
    output logic [LANES-1:0]             lane_wr,
    output logic [TAP_W-1:0]             wr_tap,
    output lenet_mac_pkg::weight_t       wr_data
);

    logic [TAP_W-1:0] tap_cnt;   // position inside the current window.
    logic             cnt_last;

    assign cnt_last = (tap_cnt == TAP_W'(KERNEL_TAPS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tap_cnt   <= '0;
            tap_valid <= 1'b0;
            tap_index <= '0;
            tap_first <= 1'b0;
            tap_last  <= 1'b0;
        end else begin
            tap_valid <= pixel_valid;
            if (pixel_valid) begin
                tap_index <= tap_cnt;
                tap_first <= (tap_cnt == '0);
                tap_last  <= cnt_last;
                tap_cnt   <= cnt_last ? '0 : tap_cnt + 1'b1;  // wrap per window.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            tap_pixel <= pixel;
        end
    end

    // one-hot lane select for weight loads.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_wr <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                lane_wr[i] <= weight_wr && (weight_lane == LANE_W'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_tap  <= weight_tap;
        wr_data <= weight_data;
    end

endmodule

`default_nettype wire

//--- lenet_mac_array.f
design/lenet_mac_pkg.sv
design/lenet_approx_mult.sv
design/tap_feeder.sv
design/mac_lane.sv
design/result_drain.sv
design/lenet_mac_array.sv
verification/lenet_mac_array_sva.sv
verification/lenet_mac_array_tb.sv

//--- verification/lenet_mac_array_sva.sv
`timescale 1ns/1ns
`default_nettype none

module lenet_mac_array_sva #(
    parameter  int LANES  = lenet_mac_pkg::DEFAULT_LANES,
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1
) (
    input wire              clk,
    input wire              arst_n,
    input wire [LANES-1:0]  lane_done,
    input wire              result_valid,
    input wire [LANE_W-1:0] result_lane
);

    logic [LANE_W:0] drain_left;  // lanes still to be walked by the drain.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_left <= '0;
        end else if (lane_done[0]) begin
            drain_left <= (LANE_W + 1)'(LANES);
        end else if (drain_left != '0) begin
            drain_left <= drain_left - 1'b1;
        end
    end

    lane_in_order: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> int'(result_lane) == LANES - int'($past(drain_left)))
        else $error("result lane out of order or beyond the last lane");

    drain_free: assert property (@(posedge clk) disable iff (!arst_n)
        lane_done != '0 |-> drain_left == '0)
        else $error("lane done arrived while the drain was still busy");

    quiet_until_done: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> $past(drain_left) != '0)
        else $error("result valid high with no drain running");

    done_to_result: assert property (@(posedge clk) disable iff (!arst_n)
        lane_done[0] |-> ##2 result_valid)
        else $error("no result followed a lane done");

endmodule

bind lenet_mac_array lenet_mac_array_sva #(
    .LANES (LANES)
) u_sva (
    .clk          (clk),
    .arst_n       (arst_n),
    .lane_done    (lane_done),
    .result_valid (result_valid),
    .result_lane  (result_lane)
);

`default_nettype wire

//--- verification/lenet_mac_array_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lenet_mac_array_tb;

    import lenet_mac_pkg::*;

    localparam int LANES      = DEFAULT_LANES;
    localparam int TAPS       = DEFAULT_TAPS;
    localparam int SHIFT      = DEFAULT_OUT_SHIFT;
    localparam int TAP_W      = $clog2(TAPS);
    localparam int LANE_W     = $clog2(LANES);
    localparam int WINDOWS    = 8;
    localparam int LOADS      = 6;
    localparam int MAX_CYCLES = WINDOWS * (TAPS * 2 + LANES + 10) + LOADS * LANES * TAPS;

    logic              clk;
    logic              arst_n;
    logic              pixel_valid;
    act_t              pixel;
    logic              weight_wr;
    logic [LANE_W-1:0] weight_lane;
    logic [TAP_W-1:0]  weight_tap;
    weight_t           weight_data;
    logic              result_valid;
    logic [LANE_W-1:0] result_lane;
    act_t              result_data;

    integer  seed;
    weight_t w_model [LANES][TAPS];  // mirror of the lane weight stores.
    act_t    pix_buf [TAPS];
    int      exp_lane [$];
    act_t    exp_data [$];
    int      want_lane;
    act_t    want_data;

    lenet_mac_array #(
        .LANES       (LANES),
        .KERNEL_TAPS (TAPS),
        .OUT_SHIFT   (SHIFT)
    ) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .weight_wr    (weight_wr),
        .weight_lane  (weight_lane),
        .weight_tap   (weight_tap),
        .weight_data  (weight_data),
        .result_valid (result_valid),
        .result_lane  (result_lane),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // approximate product; rows 6 and 7 exact, rows 0 to 5 merged in pairs.
    function automatic int xfyw_ref(input act_t x, input weight_t y);
        int c;
        c = 0;
        c += int'((x[0] & y[3]) | (x[1] & y[2])) << 3;
        c += int'((x[0] & y[4]) & (x[1] & y[3])) << 4;
        c += int'((x[0] & y[6]) | (x[1] & y[5])) << 6;
        c += int'((x[0] & y[7]) ^ (x[1] & y[6])) << 7;
        c += int'(x[1] & y[7]) << 8;
        c += int'((x[2] & y[6]) & (x[3] & y[5])) << 9;
        c += int'(x[3] & y[7]) << 10;
        c += int'((x[4] & y[6]) & (x[5] & y[5])) << 11;
        c += int'((x[4] & y[7]) & (x[5] & y[6])) << 12;
        c += int'((x[2] & y[2]) & (x[3] & y[1])) << 4;
        c += int'((x[4] & y[1]) & (x[5] & y[0])) << 6;
        c += int'((x[2] & y[4]) ^ (x[3] & y[3])) << 7;
        c += int'((x[2] & y[5]) | (x[3] & y[4])) << 8;
        c += int'((x[2] & y[7]) | (x[3] & y[6])) << 9;
        c += int'((x[4] & y[5]) & (x[5] & y[4])) << 10;
        c += int'((x[4] & y[7]) ^ (x[5] & y[6])) << 11;
        c += int'(x[5] & y[7]) << 12;
        c += int'((x[4] & y[1]) | (x[5] & y[0])) << 6;
        c += int'((x[4] & y[3]) ^ (x[5] & y[2])) << 7;
        c += int'((x[2] & y[6]) ^ (x[3] & y[5])) << 8;
        c += int'((x[4] & y[5]) ^ (x[5] & y[4])) << 9;
        c += int'((x[4] & y[6]) ^ (x[5] & y[5])) << 10;
        c += int'((x[4] & y[4]) & (x[5] & y[3])) << 8;
        c += int'((x[4] & y[4]) | (x[5] & y[3])) << 8;
        return c + (x[6] ? int'(y) << 6 : 0) + (x[7] ? int'(y) << 7 : 0);
    endfunction

    function automatic act_t lane_expect(input int lane, input bit exact);
        int sum;
        sum = 0;
        for (int t = 0; t < TAPS; t++) begin
            if (exact) begin
                sum += int'(pix_buf[t]) * int'(w_model[lane][t]);
            end else begin
                sum += xfyw_ref(pix_buf[t], w_model[lane][t]);
            end
        end
        sum = sum >> SHIFT;
        return (sum > 255) ? 8'hff : act_t'(sum);
    endfunction

    task automatic print_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
    endtask

    task automatic idle_cycle;
        @(posedge clk);
        #1;
        pixel_valid = 1'b0;
        weight_wr   = 1'b0;
    endtask

    task automatic write_weight(input int lane, input int tap, input weight_t data);
        @(posedge clk);
        #1;
        pixel_valid = 1'b0;
        weight_wr   = 1'b1;
        weight_lane = LANE_W'(lane);
        weight_tap  = TAP_W'(tap);
        weight_data = data;
        w_model[lane][tap] = data;
    endtask

    task automatic load_random_weights;
        for (int l = 0; l < LANES; l++) begin
            for (int t = 0; t < TAPS; t++) begin
                if (t % (2 * LANES) == l) begin  // a few full-range taps per lane.
                    write_weight(l, t, weight_t'($random(seed)));
                end else begin
                    write_weight(l, t, weight_t'($random(seed)) >> 6);
                end
            end
        end
    endtask

    // mode 1 keeps only bits 6 and 7, mode 3 is full scale.
    task automatic run_window(input int mode, input bit exact, input int max_gap);
        act_t r;
        int   gap;
        for (int t = 0; t < TAPS; t++) begin
            r = act_t'($random(seed));
            pix_buf[t] = (mode == 1) ? (r & 8'hc0) : ((mode == 3) ? 8'hff : r);
        end
        for (int l = 0; l < LANES; l++) begin
            exp_lane.push_back(l);
            exp_data.push_back(lane_expect(l, exact));
        end
        for (int t = 0; t < TAPS; t++) begin
            @(posedge clk);
            #1;
            weight_wr   = 1'b0;
            pixel_valid = 1'b1;
            pixel       = pix_buf[t];
            gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) idle_cycle();
        end
    endtask

    task automatic wait_drained;
        int cycles;
        cycles = 0;
        idle_cycle();
        while (exp_data.size() != 0) begin
            idle_cycle();
            cycles++;
            assert (cycles < TAPS + LANES + 10)
                else begin
                    print_failure("expected results never arrived");
                    $fatal(1);
                end
        end
    endtask

    task automatic zero_weight_window;
        run_window(2, 1'b0, 0);
        wait_drained();
    endtask

    task automatic exact_product_window;
        load_random_weights();
        run_window(1, 1'b1, 0);
        wait_drained();
    endtask

    task automatic random_weight_windows;
        load_random_weights();
        run_window(2, 1'b0, 0);
        run_window(2, 1'b0, 0);  // back to back.
        wait_drained();
    endtask

    task automatic saturation_window;
        for (int l = 0; l < LANES; l++) begin
            for (int t = 0; t < TAPS; t++) begin
                write_weight(l, t, (l == LANES - 1) ? weight_t'(t % 4 + 1) : 8'hff);
            end
        end
        run_window(3, 1'b0, 0);
        wait_drained();
    endtask

    task automatic weight_reload_windows;
        repeat (3) begin
            load_random_weights();
            run_window(2, 1'b0, 1);
        end
        wait_drained();
    endtask

    always @(negedge clk) begin
        if (arst_n && result_valid) begin
            assert (exp_data.size() != 0) begin
                want_lane = exp_lane.pop_front();
                want_data = exp_data.pop_front();
                assert (int'(result_lane) == want_lane)
                    else begin
                        print_failure($sformatf("Fail result_lane: got %h, expected %h",
                                                result_lane, want_lane));
                        $fatal(1);
                    end
                assert (result_data == want_data)
                    else begin
                        print_failure($sformatf("Fail result_data: got %h, expected %h",
                                                result_data, want_data));
                        $fatal(1);
                    end
            end else begin
                print_failure("an extra result appeared on the output");
                $fatal(1);
            end
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        print_failure("the run did not finish in time");
        $fatal(1);
    end

    initial begin
        seed        = 32'hd10c;
        arst_n      = 1'b0;
        pixel_valid = 1'b0;
        pixel       = '0;
        weight_wr   = 1'b0;
        weight_lane = '0;
        weight_tap  = '0;
        weight_data = '0;
        for (int l = 0; l < LANES; l++) begin
            for (int t = 0; t < TAPS; t++) begin
                w_model[l][t] = '0;  // lanes come out of reset with zero weights.
            end
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        zero_weight_window();
        exact_product_window();
        random_weight_windows();
        saturation_window();
        weight_reload_windows();
        repeat (LANES + 5) idle_cycle();
        if (exp_data.size() != 0) begin
            print_failure("results were missing at the end of the run");
            $fatal(1);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
